/* hw/decodePkg.sv */
`default_nettype none

package decodePkg;

  // Datapath dimensions
  localparam int dataW   = 16;
  localparam int regSelW = 3;
  localparam int numRegs = 8;

  typedef logic [dataW-1:0]   wordT;    // Data or instruction word
  typedef logic [regSelW-1:0] regSelT;  // Register index
  typedef logic [4:0]         opcodeT;  // Instruction bits 15 to 11
  typedef logic [3:0]         aluOpT;
  typedef logic [1:0]         selT;     // bSrc, regSrc and regDst codes

  localparam wordT nopInstr = 16'h0800;

  // Opcodes
  localparam opcodeT opHalt  = 5'b00000;
  localparam opcodeT opNop   = 5'b00001;
  localparam opcodeT opAddi  = 5'b01000;
  localparam opcodeT opSubi  = 5'b01001;
  localparam opcodeT opXori  = 5'b01010;
  localparam opcodeT opAndni = 5'b01011;
  localparam opcodeT opBeqz  = 5'b01100;
  localparam opcodeT opBnez  = 5'b01101;
  localparam opcodeT opJ     = 5'b00100;
  localparam opcodeT opJr    = 5'b00101;
  localparam opcodeT opJal   = 5'b00110;
  localparam opcodeT opJalr  = 5'b00111;
  localparam opcodeT opSt    = 5'b10000;
  localparam opcodeT opLd    = 5'b10001;
  localparam opcodeT opSlbi  = 5'b10010;
  localparam opcodeT opLbi   = 5'b11000;
  localparam opcodeT opBtr   = 5'b11001;
  localparam opcodeT opAlu   = 5'b11011;
  localparam opcodeT opSeq   = 5'b11100;

  // Destination register codes
  localparam selT dstRs = 2'd0;
  localparam selT dstRt = 2'd1;
  localparam selT dstRd = 2'd2;
  localparam selT dstR7 = 2'd3;  // Link register

  // ALU B operand source
  localparam selT bSrcReg = 2'd0;
  localparam selT bSrcImm = 2'd1;
  localparam selT bSrcLbi = 2'd2;  // 8-bit immediate for LBI and SLBI

  // Writeback source
  localparam selT regSrcAlu = 2'd0;
  localparam selT regSrcMem = 2'd1;
  localparam selT regSrcPc  = 2'd2;  // Return address for JAL and JALR

endpackage

`default_nettype wire

/* hw/decodeIfs.sv */
`default_nettype none

interface regReadIf;
  import decodePkg::*;

  regSelT rsSel;
  regSelT rtSel;
  wordT   rsData;  // Bypassed read data
  wordT   rtData;

  modport requester (output rsSel, output rtSel, input rsData, input rtData);
  modport regFile (input rsSel, input rtSel, output rsData, output rtData);
endinterface

interface decodeCtrlIf;
  import decodePkg::*;

  aluOpT aluOp;
  selT   regSrc;
  selT   bSrc;
  selT   regDst;
  logic  regWrt, slbi, branch, zeroExt, set, sub, memEn;
  logic  invA, invB, memWrt, immSrc, aluJmp, halt, btr, jmp;

  modport source (
    output aluOp, regSrc, bSrc, regDst, regWrt, slbi, branch, zeroExt,
    output set, sub, memEn, invA, invB, memWrt, immSrc, aluJmp, halt, btr, jmp
  );

  modport sink (
    input aluOp, regSrc, bSrc, regDst, regWrt, slbi, branch, zeroExt,
    input set, sub, memEn, invA, invB, memWrt, immSrc, aluJmp, halt, btr, jmp
  );
endinterface

`default_nettype wire

/* hw/instrDecoder.sv */
`default_nettype none

module instrDecoder (
  input  decodePkg::opcodeT opcode,
  decodeCtrlIf.source       ctrl
);
  import decodePkg::*;

  always_comb begin
    ctrl.aluOp   = opcode[3:0];  // ALU op rides in the low opcode bits
    ctrl.regSrc  = regSrcAlu;
    ctrl.bSrc    = bSrcReg;
    ctrl.regDst  = dstRs;
    ctrl.regWrt  = 1'b1;  // Most instructions write back
    ctrl.slbi    = 1'b0;
    ctrl.branch  = 1'b0;
    ctrl.zeroExt = 1'b0;
    ctrl.set     = 1'b0;
    ctrl.sub     = 1'b0;
    ctrl.memEn   = 1'b0;
    ctrl.invA    = 1'b0;
    ctrl.invB    = 1'b0;
    ctrl.memWrt  = 1'b0;
    ctrl.immSrc  = 1'b0;
    ctrl.aluJmp  = 1'b0;
    ctrl.halt    = 1'b0;
    ctrl.btr     = 1'b0;
    ctrl.jmp     = 1'b0;

    case (opcode)
      opHalt: begin
        ctrl.halt   = 1'b1;
        ctrl.aluOp  = '0;
        ctrl.regWrt = 1'b0;
      end
      opNop: begin
        ctrl.aluOp  = '0;
        ctrl.regWrt = 1'b0;
      end
      opAddi, opSubi, opXori, opAndni: begin
        ctrl.regDst  = dstRt;
        ctrl.immSrc  = 1'b1;
        ctrl.bSrc    = bSrcImm;
        ctrl.sub     = (opcode == opSubi);
        ctrl.invA    = (opcode == opSubi);  // B minus A via inverted A
        ctrl.zeroExt = (opcode == opXori) || (opcode == opAndni);
        ctrl.invB    = (opcode == opAndni);
      end
      opBeqz, opBnez: begin
        ctrl.branch = 1'b1;
        ctrl.regWrt = 1'b0;
      end
      opJ, opJr: begin
        ctrl.jmp    = 1'b1;
        ctrl.aluJmp = (opcode == opJr);  // Target from Rs plus imm
        ctrl.regWrt = 1'b0;
      end
      opJal, opJalr: begin
        ctrl.jmp    = 1'b1;
        ctrl.aluJmp = (opcode == opJalr);
        ctrl.regDst = dstR7;
        ctrl.regSrc = regSrcPc;
      end
      opSt: begin
        ctrl.memEn  = 1'b1;
        ctrl.memWrt = 1'b1;
        ctrl.immSrc = 1'b1;
        ctrl.bSrc   = bSrcImm;
        ctrl.regWrt = 1'b0;
      end
      opLd: begin
        ctrl.memEn  = 1'b1;
        ctrl.immSrc = 1'b1;
        ctrl.bSrc   = bSrcImm;
        ctrl.regDst = dstRt;
        ctrl.regSrc = regSrcMem;
      end
      opSlbi, opLbi: begin
        ctrl.slbi   = (opcode == opSlbi);
        ctrl.bSrc   = bSrcLbi;
        ctrl.regDst = dstRs;
      end
      opBtr: begin
        ctrl.btr    = 1'b1;
        ctrl.regDst = dstRd;
      end
      opAlu, opSeq: begin
        ctrl.set    = (opcode == opSeq);
        ctrl.regDst = dstRd;
      end
      default: begin
        ctrl.regDst = dstRs;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/regFileBypass.sv */
`default_nettype none

module regFileBypass (
  input  logic              clk,
  input  logic              arstN,
  regReadIf.regFile         rd,
  input  logic              writeEn,
  input  decodePkg::regSelT writeSel,
  input  decodePkg::wordT   writeData
);
  import decodePkg::*;

  wordT regs [numRegs];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeSel] <= writeData;
    end
  end

  logic rsHit;
  logic rtHit;

  // Writeback in flight this cycle
  assign rsHit = writeEn && (rd.rsSel == writeSel);
  assign rtHit = writeEn && (rd.rtSel == writeSel);

  assign rd.rsData = rsHit ? writeData : regs[rd.rsSel];
  assign rd.rtData = rtHit ? writeData : regs[rd.rtSel];

endmodule

`default_nettype wire

/* hw/hazardDetect.sv */
`default_nettype none

module hazardDetect (
  input  logic              clk,
  input  logic              arstN,
  input  logic              stall,
  input  logic              memRead,
  input  logic              pcSrcX,
  input  decodePkg::regSelT regRtE,
  input  decodePkg::regSelT fdRs,
  input  decodePkg::regSelT fdRt,
  output logic              hazard,
  output logic              flush,
  output logic              prevHaz
);

  logic rtMatch;

  // Load in execute targets a source of the fetched instruction
  assign rtMatch = (regRtE == fdRs) || (regRtE == fdRt);
  assign hazard  = memRead && rtMatch && !stall;
  assign flush   = pcSrcX;  // Taken branch or jump resolved in execute

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevHaz <= 1'b0;
    end else begin
      prevHaz <= hazard;
    end
  end

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`default_nettype none

module decodeStage (
  input  logic              clk,
  input  logic              arstN,
  input  logic              dataMemStall,
  input  logic              instrMemStall,
  input  logic              pcSrcX,
  input  logic              memReadE,
  input  logic              regWriteWb,
  input  decodePkg::wordT   instrFd,
  input  decodePkg::wordT   writeDataWb,
  input  decodePkg::regSelT writeRegSelWb,
  input  decodePkg::regSelT regRtE,
  output decodePkg::wordT   read1Data,
  output decodePkg::wordT   read2Data,
  output decodePkg::wordT   imm5Ext,
  output decodePkg::wordT   imm8Ext,
  output decodePkg::wordT   imm11Ext,
  output decodePkg::wordT   instrOut,
  output decodePkg::aluOpT  aluOp,
  output decodePkg::selT    bSrc,
  output decodePkg::selT    regSrc,
  output logic [1:0]        instrFunct,
  output logic [1:0]        brchCndSel,
  output decodePkg::regSelT registerRs,
  output decodePkg::regSelT registerRt,
  output decodePkg::regSelT writeRegSel,
  output logic              immSrc, invA, invB, memWrt, regWrt, branch, set, sub,
  output logic              memEn, aluJmp, slbi, halt, btr, jmp, hazard, flushOut
);
  import decodePkg::*;

  wordT instr;      // Instruction after NOP insertion and replay
  wordT prevInstr;  // Fetched word from the last cycle
  logic prevHaz;

  regReadIf    rdBus ();
  decodeCtrlIf ctrlBus ();

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevInstr <= nopInstr;
    end else begin
      prevInstr <= instrFd;
    end
  end

  always_comb begin
    if (hazard || flushOut || dataMemStall) begin
      instr = nopInstr;
    end else if (prevHaz && (prevInstr != nopInstr)) begin
      instr = prevInstr;  // Replay the stalled instruction
    end else begin
      instr = instrFd;
    end
  end

  assign instrOut   = instr;
  assign registerRs = instr[10:8];
  assign registerRt = instr[7:5];
  assign instrFunct = instr[1:0];
  assign brchCndSel = instr[12:11];

  instrDecoder uDecoder (.opcode(instr[15:11]), .ctrl(ctrlBus.source));

  assign aluOp  = ctrlBus.aluOp;
  assign bSrc   = ctrlBus.bSrc;
  assign regSrc = ctrlBus.regSrc;
  assign immSrc = ctrlBus.immSrc;
  assign invA   = ctrlBus.invA;
  assign invB   = ctrlBus.invB;
  assign memWrt = ctrlBus.memWrt;
  assign regWrt = ctrlBus.regWrt;
  assign branch = ctrlBus.branch;
  assign set    = ctrlBus.set;
  assign sub    = ctrlBus.sub;
  assign memEn  = ctrlBus.memEn;
  assign aluJmp = ctrlBus.aluJmp;
  assign slbi   = ctrlBus.slbi;
  assign halt   = ctrlBus.halt;
  assign btr    = ctrlBus.btr;
  assign jmp    = ctrlBus.jmp;

  assign imm5Ext  = ctrlBus.zeroExt ? {11'h000, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
  assign imm8Ext  = ctrlBus.zeroExt ? {8'h00, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
  assign imm11Ext = {{5{instr[10]}}, instr[10:0]};  // Jump displacement

  always_comb begin
    case (ctrlBus.regDst)
      dstRs:   writeRegSel = instr[10:8];
      dstRt:   writeRegSel = instr[7:5];
      dstRd:   writeRegSel = instr[4:2];
      default: writeRegSel = 3'd7;
    endcase
  end

  assign rdBus.rsSel = registerRs;
  assign rdBus.rtSel = registerRt;
  assign read1Data   = rdBus.rsData;
  assign read2Data   = rdBus.rtData;

  regFileBypass uRegFile (
    .clk       (clk),
    .arstN     (arstN),
    .rd        (rdBus.regFile),
    .writeEn   (regWriteWb),
    .writeSel  (writeRegSelWb),
    .writeData (writeDataWb)
  );

  // Hazard check looks at the raw fetched fields
  hazardDetect uHazard (
    .clk     (clk),
    .arstN   (arstN),
    .stall   (dataMemStall || instrMemStall),
    .memRead (memReadE),
    .pcSrcX  (pcSrcX),
    .regRtE  (regRtE),
    .fdRs    (instrFd[10:8]),
    .fdRt    (instrFd[7:5]),
    .hazard  (hazard),
    .flush   (flushOut),
    .prevHaz (prevHaz)
  );

endmodule

`default_nettype wire

/* verification/decodeStageTb.sv */
`default_nettype none

module decodeStageTb;
  timeunit 1ns;
  timeprecision 1ps;
  import decodePkg::*;

  typedef struct packed {
    wordT       instr, rd1, rd2, imm5, imm8, imm11;
    regSelT     rs, rt, wsel;
    logic [1:0] funct, brc;
    aluOpT      aluOp;
    selT        bSrc, regSrc;
    logic [15:0] flags;  // Order of actFlags below
  } expT;

  logic   clk, arstN, dataMemStall, instrMemStall, pcSrcX, memReadE, regWriteWb;
  wordT   instrFd, writeDataWb, read1Data, read2Data, imm5Ext, imm8Ext, imm11Ext, instrOut;
  regSelT writeRegSelWb, regRtE, registerRs, registerRt, writeRegSel;
  aluOpT  aluOp;
  selT    bSrc, regSrc;
  logic [1:0] instrFunct, brchCndSel;
  logic   immSrc, invA, invB, memWrt, regWrt, branch, set, sub;
  logic   memEn, aluJmp, slbi, halt, btr, jmp, hazard, flushOut;

  wordT        mRegs [numRegs];  // Model register file
  wordT        mPrevInstr = nopInstr;
  logic        mPrevHaz = 1'b0;
  logic        checkOn = 1'b0;
  logic [31:0] lcgState = 32'd56;
  int          errCount = 0;
  int          passTests = 0;
  int          failTests = 0;
  string       flagNames [15:0] = '{"immSrc", "invA", "invB", "memWrt", "regWrt", "branch",
    "set", "sub", "memEn", "aluJmp", "slbi", "halt", "btr", "jmp", "hazard", "flushOut"};

  decodeStage DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic wordT randWord();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[31:16];
  endfunction

  // Expected stage outputs from the current inputs and model state
  function automatic expT refModel();
    expT    e;
    wordT   ins;
    opcodeT op;
    logic   haz, zx, immAlu, memOp;
    selT    dst;
    regSelT rs, rt;
    haz = memReadE && ((regRtE == instrFd[10:8]) || (regRtE == instrFd[7:5]))
          && !(dataMemStall || instrMemStall);
    if (haz || pcSrcX || dataMemStall) ins = nopInstr;
    else if (mPrevHaz && (mPrevInstr != nopInstr)) ins = mPrevInstr;
    else ins = instrFd;
    op = ins[15:11];
    rs = ins[10:8];
    rt = ins[7:5];
    immAlu = op inside {opAddi, opSubi, opXori, opAndni};
    memOp = op inside {opSt, opLd};
    zx = op inside {opXori, opAndni};
    case (op)
      opAddi, opSubi, opXori, opAndni, opLd: dst = 2'd1;
      opAlu, opSeq, opBtr: dst = 2'd2;
      opJal, opJalr: dst = 2'd3;
      default: dst = 2'd0;  // LBI and SLBI use Rs
    endcase
    e.instr = ins;
    e.rd1 = (regWriteWb && writeRegSelWb == rs) ? writeDataWb : mRegs[rs];
    e.rd2 = (regWriteWb && writeRegSelWb == rt) ? writeDataWb : mRegs[rt];
    e.imm5 = zx ? {11'd0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
    e.imm8 = zx ? {8'd0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
    e.imm11 = {{5{ins[10]}}, ins[10:0]};
    e.rs = rs;
    e.rt = rt;
    e.wsel = (dst == 2'd0) ? rs : (dst == 2'd1) ? rt : (dst == 2'd2) ? ins[4:2] : 3'd7;
    e.funct = ins[1:0];
    e.brc = ins[12:11];
    e.aluOp = (op == opHalt || op == opNop) ? 4'd0 : op[3:0];
    e.bSrc = (immAlu || memOp) ? 2'd1 : (op inside {opLbi, opSlbi}) ? 2'd2 : 2'd0;
    e.regSrc = (op == opLd) ? 2'd1 : (op inside {opJal, opJalr}) ? 2'd2 : 2'd0;
    e.flags = {immAlu || memOp, op == opSubi, op == opAndni, op == opSt,
      !(op inside {opHalt, opNop, opSt, opBeqz, opBnez, opJ, opJr}),
      op inside {opBeqz, opBnez}, op == opSeq, op == opSubi, memOp,
      op inside {opJr, opJalr}, op == opSlbi, op == opHalt, op == opBtr,
      op inside {opJ, opJr, opJal, opJalr}, haz, pcSrcX};
    return e;
  endfunction

  task automatic checkVal(string name, logic [15:0] expVal, logic [15:0] actVal);
    if (actVal !== expVal) begin
      errCount++;
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
    end
  endtask

  task automatic compareAll(expT e);
    logic [15:0] actFlags;
    actFlags = {immSrc, invA, invB, memWrt, regWrt, branch, set, sub,
                memEn, aluJmp, slbi, halt, btr, jmp, hazard, flushOut};
    checkVal("instrOut", e.instr, instrOut);
    checkVal("read1Data", e.rd1, read1Data);
    checkVal("read2Data", e.rd2, read2Data);
    checkVal("imm5Ext", e.imm5, imm5Ext);
    checkVal("imm8Ext", e.imm8, imm8Ext);
    checkVal("imm11Ext", e.imm11, imm11Ext);
    checkVal("registerRs", 16'(e.rs), 16'(registerRs));
    checkVal("registerRt", 16'(e.rt), 16'(registerRt));
    checkVal("writeRegSel", 16'(e.wsel), 16'(writeRegSel));
    checkVal("instrFunct", 16'(e.funct), 16'(instrFunct));
    checkVal("brchCndSel", 16'(e.brc), 16'(brchCndSel));
    checkVal("aluOp", 16'(e.aluOp), 16'(aluOp));
    checkVal("bSrc", 16'(e.bSrc), 16'(bSrc));
    checkVal("regSrc", 16'(e.regSrc), 16'(regSrc));
    for (int i = 0; i < 16; i++) begin
      checkVal(flagNames[i], 16'(e.flags[i]), 16'(actFlags[i]));
    end
  endtask

  // State the DUT captures at the coming edge
  task automatic updateModel(expT e);
    if (!arstN) begin
      mPrevInstr = nopInstr;
      mPrevHaz = 1'b0;
      for (int i = 0; i < numRegs; i++) mRegs[i] = '0;
    end else begin
      mPrevInstr = instrFd;
      mPrevHaz = e.flags[1];
      if (regWriteWb) mRegs[writeRegSelWb] = writeDataWb;
    end
  endtask

  // Samples 5 ns before each rising edge
  initial begin
    expT e;
    forever begin
      @(posedge clk);
      #95;
      e = refModel();
      if (checkOn) compareAll(e);
      updateModel(e);
    end
  end

  task automatic reportTest(string name, int errsBefore);
    @(negedge clk);
    #46;  // Past the last compare of the test
    if (errCount == errsBefore) begin
      passTests++;
      $display("test %s: ok", name);
    end else begin
      failTests++;
      $display("test %s: %0d errors", name, errCount - errsBefore);
    end
  endtask

  initial begin
    #300000;
    $display("Timeout: run did not complete in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int   errsAt;
    wordT w;
    wordT d;
    arstN = 1'b0;
    dataMemStall = 1'b0;
    instrMemStall = 1'b0;
    pcSrcX = 1'b0;
    memReadE = 1'b0;
    regWriteWb = 1'b0;
    instrFd = nopInstr;
    writeDataWb = '0;
    writeRegSelWb = '0;
    regRtE = '0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    @(posedge clk);
    checkOn = 1'b1;

    errsAt = errCount;
    for (int i = 0; i < numRegs; i++) begin
      @(posedge clk);
      w = randWord();
      w[10:8] = i[2:0];
      w[7:5] = 3'(7 - i);
      instrFd <= w;
      #90;
      checkVal("instrOut", w, instrOut);
      checkVal("read1Data", 16'h0000, read1Data);
      checkVal("read2Data", 16'h0000, read2Data);
      checkVal("hazard", 16'h0000, 16'(hazard));
      checkVal("flushOut", 16'h0000, 16'(flushOut));
    end
    reportTest("after reset", errsAt);

    errsAt = errCount;
    repeat (200) begin
      @(posedge clk);
      instrFd <= randWord();
      regRtE <= 3'(randWord());
    end
    reportTest("decode and immediates", errsAt);

    errsAt = errCount;
    for (int i = 0; i < numRegs; i++) begin
      @(posedge clk);
      d = randWord();
      w = randWord();
      w[10:8] = i[2:0];  // Read the register being written
      regWriteWb <= 1'b1;
      writeRegSelWb <= i[2:0];
      writeDataWb <= d;
      instrFd <= w;
      #90;
      checkVal("read1Data", d, read1Data);
    end
    @(posedge clk);
    regWriteWb <= 1'b0;
    repeat (16) begin
      @(posedge clk);
      instrFd <= randWord();
    end
    reportTest("register file", errsAt);

    errsAt = errCount;
    @(posedge clk);
    w = {opAddi, 3'd3, 3'd5, 5'd1};
    instrFd <= w;
    memReadE <= 1'b1;
    regRtE <= 3'd3;  // Matches Rs
    #90;
    checkVal("hazard", 16'h0001, 16'(hazard));
    checkVal("instrOut", nopInstr, instrOut);
    @(posedge clk);
    memReadE <= 1'b0;
    instrFd <= {opAlu, 3'd1, 3'd2, 3'd4, 2'd0};
    #90;
    checkVal("instrOut", w, instrOut);  // Replayed word
    @(posedge clk);
    instrFd <= w;
    memReadE <= 1'b1;
    regRtE <= 3'd5;  // Matches Rt
    #90;
    checkVal("hazard", 16'h0001, 16'(hazard));
    @(posedge clk);
    dataMemStall <= 1'b1;
    #90;
    checkVal("hazard", 16'h0000, 16'(hazard));
    @(posedge clk);
    dataMemStall <= 1'b0;
    instrMemStall <= 1'b1;
    #90;
    checkVal("hazard", 16'h0000, 16'(hazard));
    @(posedge clk);
    instrMemStall <= 1'b0;
    memReadE <= 1'b0;
    reportTest("load-use hazard", errsAt);

    errsAt = errCount;
    @(posedge clk);
    instrFd <= {opLd, 3'd2, 3'd6, 5'd4};
    pcSrcX <= 1'b1;
    #90;
    checkVal("flushOut", 16'h0001, 16'(flushOut));
    checkVal("instrOut", nopInstr, instrOut);
    checkVal("regWrt", 16'h0000, 16'(regWrt));
    checkVal("aluOp", 16'h0000, 16'(aluOp));
    @(posedge clk);
    pcSrcX <= 1'b0;
    dataMemStall <= 1'b1;
    #90;
    checkVal("instrOut", nopInstr, instrOut);
    checkVal("regWrt", 16'h0000, 16'(regWrt));
    checkVal("aluOp", 16'h0000, 16'(aluOp));
    @(posedge clk);
    dataMemStall <= 1'b0;
    reportTest("flush and data stall", errsAt);

    $display("tests passed %0d failed %0d, check errors %0d", passTests, failTests, errCount);
    if (failTests == 0 && errCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/decodePkg.sv
hw/decodeIfs.sv
hw/instrDecoder.sv
hw/regFileBypass.sv
hw/hazardDetect.sv
hw/decodeStage.sv
verification/decodeStageTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module decodeStageTb \
  -f src.f --Mdir build -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./build/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "No pass message in sim.log"
  exit 1
fi
exit 0
